// File: hdl/aluPkg.sv
package aluPkg;

  // Operand and result width.
  localparam int dataWidth = 32;

  // Cycles from an input strobe to the matching output strobe.
  localparam int pipeLatency = 2;

  // Operation codes, equal to the external opcode values.
  // Codes 6 and 7 are not defined and decode as illegal.
  typedef enum logic [2:0] {
    opAdd = 3'd0,
    opSub = 3'd1,
    opAnd = 3'd2,
    opOr  = 3'd3,
    opXor = 3'd4,
    opSlt = 3'd5
  } aluOp;

endpackage

// File: hdl/claBlock4.sv
`timescale 1ns/1ps

module claBlock4 (
  input  logic [3:0] a,
  input  logic [3:0] b,
  input  logic       cin,
  output logic [3:0] sum,
  output logic       grpProp,
  output logic       grpGen
);

  logic [3:0] p;
  logic [3:0] g;
  logic       c1;
  logic       c2;
  logic       c3;

  assign p = a ^ b;
  assign g = a & b;

  // Lookahead carries into bits 1 to 3.
  assign c1 = g[0] ^ (p[0] & cin);
  assign c2 = g[1] ^ (p[1] & g[0]) ^ (p[1] & p[0] & cin);
  assign c3 = g[2] ^ (p[2] & g[1]) ^ (p[2] & p[1] & g[0]) ^
              (p[2] & p[1] & p[0] & cin);

  assign sum = p ^ {c3, c2, c1, cin};

  // Group terms for the next lookahead level.
  assign grpProp = &p;
  assign grpGen = g[3] ^ (p[3] & g[2]) ^ (p[3] & p[2] & g[1]) ^
                  (p[3] & p[2] & p[1] & g[0]);

endmodule

// File: hdl/claAdder32.sv
`timescale 1ns/1ps

module claAdder32 import aluPkg::*; (
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  logic                 cin,
  output logic [dataWidth-1:0] sum,
  output logic                 cout,
  output logic                 carryIntoMsb
);

  localparam int numGroups = dataWidth / 4;
  localparam int numPairs = numGroups / 2;

  logic [numGroups-1:0] grpProp;
  logic [numGroups-1:0] grpGen;
  logic [numGroups:0]   grpCarry;
  logic [numPairs-1:0]  pairProp;
  logic [numPairs-1:0]  pairGen;

  assign grpCarry[0] = cin;

  genvar i;
  generate
    for (i = 0; i < numGroups; i++) begin : genGroup
      claBlock4 claBlock4_inst (
        .a       (a[4*i+3:4*i]),
        .b       (b[4*i+3:4*i]),
        .cin     (grpCarry[i]),
        .sum     (sum[4*i+3:4*i]),
        .grpProp (grpProp[i]),
        .grpGen  (grpGen[i])
      );
    end

    // Two groups are looked ahead together, and the pair carry ripples on.
    for (i = 0; i < numPairs; i++) begin : genPair
      assign pairProp[i] = grpProp[2*i+1] & grpProp[2*i];
      assign pairGen[i] = grpGen[2*i+1] ^ (grpProp[2*i+1] & grpGen[2*i]);

      assign grpCarry[2*i+1] = grpGen[2*i] ^ (grpProp[2*i] & grpCarry[2*i]);
      assign grpCarry[2*i+2] = pairGen[i] ^ (pairProp[i] & grpCarry[2*i]);
    end
  endgenerate

  assign cout = grpCarry[numGroups];

  // Sum bit is a ^ b ^ carry, so the carry into the top bit falls out.
  assign carryIntoMsb = sum[dataWidth-1] ^ a[dataWidth-1] ^ b[dataWidth-1];

endmodule

// File: hdl/opDecode.sv
`timescale 1ns/1ps

module opDecode import aluPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inValid,
  input  logic [2:0]           opCode,
  input  logic [dataWidth-1:0] opA,
  input  logic [dataWidth-1:0] opB,
  output logic                 decValid,
  output aluOp                 decOp,
  output logic                 decIllegal,
  output logic [dataWidth-1:0] decA,
  output logic [dataWidth-1:0] decB
);

  aluOp nextOp;
  logic nextIllegal;

  always_comb begin
    nextOp = opAdd;
    nextIllegal = 1'b0;
    case (opCode)
      3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5: begin
        nextOp = aluOp'(opCode);
      end
      default: begin
        // Undefined code runs as a harmless add.
        nextIllegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      decValid <= 1'b0;
      decOp <= opAdd;
      decIllegal <= 1'b0;
    end else begin
      decValid <= inValid;
      if (inValid) begin
        decOp <= nextOp;
        decIllegal <= nextIllegal;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (inValid) begin
      decA <= opA;
      decB <= opB;
    end
  end

endmodule

// File: hdl/aluExecute.sv
`timescale 1ns/1ps

module aluExecute import aluPkg::*; (
  input  logic                 decValid,
  input  aluOp                 decOp,
  input  logic                 decIllegal,
  input  logic [dataWidth-1:0] decA,
  input  logic [dataWidth-1:0] decB,
  output logic                 exValid,
  output logic [dataWidth-1:0] exResult,
  output logic                 exCarry,
  output logic                 exOverflow,
  output logic                 exZero,
  output logic                 exIllegal
);

  logic                 subtract;
  logic [dataWidth-1:0] addB;
  logic [dataWidth-1:0] addSum;
  logic                 addCout;
  logic                 addMsbCarry;
  logic                 addOverflow;

  // Subtract and compare add the inverted operand plus one.
  assign subtract = (decOp == opSub) || (decOp == opSlt);
  assign addB = subtract ? ~decB : decB;

  claAdder32 claAdder32_inst (
    .a            (decA),
    .b            (addB),
    .cin          (subtract),
    .sum          (addSum),
    .cout         (addCout),
    .carryIntoMsb (addMsbCarry)
  );

  assign addOverflow = addMsbCarry ^ addCout;

  always_comb begin
    exResult = '0;
    exCarry = 1'b0;
    exOverflow = 1'b0;
    if (!decIllegal) begin
      case (decOp)
        opAdd, opSub: begin
          exResult = addSum;
          exCarry = addCout;
          exOverflow = addOverflow;
        end
        opAnd: exResult = decA & decB;
        opOr: exResult = decA | decB;
        opXor: exResult = decA ^ decB;
        opSlt: exResult = {{(dataWidth-1){1'b0}}, addSum[dataWidth-1] ^ addOverflow};
        default: exResult = '0;
      endcase
    end
  end

  assign exZero = !decIllegal && (exResult == '0);
  assign exValid = decValid;
  assign exIllegal = decIllegal;

endmodule

// File: hdl/resultStage.sv
`timescale 1ns/1ps

module resultStage import aluPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 exValid,
  input  logic [dataWidth-1:0] exResult,
  input  logic                 exCarry,
  input  logic                 exOverflow,
  input  logic                 exZero,
  input  logic                 exIllegal,
  output logic                 outValid,
  output logic [dataWidth-1:0] result,
  output logic                 carry,
  output logic                 overflow,
  output logic                 zero,
  output logic                 illegalOp
);

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
      result <= '0;
      carry <= 1'b0;
      overflow <= 1'b0;
      zero <= 1'b0;
      illegalOp <= 1'b0;
    end else begin
      outValid <= exValid;
      // Word and flags hold until the next strobe.
      if (exValid) begin
        result <= exResult;
        carry <= exCarry;
        overflow <= exOverflow;
        zero <= exZero;
        illegalOp <= exIllegal;
      end
    end
  end

endmodule

// File: hdl/aluTop.sv
`timescale 1ns/1ps

module aluTop import aluPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inValid,
  input  logic [2:0]           opCode,
  input  logic [dataWidth-1:0] opA,
  input  logic [dataWidth-1:0] opB,
  output logic                 outValid,
  output logic [dataWidth-1:0] result,
  output logic                 carry,
  output logic                 overflow,
  output logic                 zero,
  output logic                 illegalOp
);

  logic                 decValid;
  aluOp                 decOp;
  logic                 decIllegal;
  logic [dataWidth-1:0] decA;
  logic [dataWidth-1:0] decB;
  logic                 exValid;
  logic [dataWidth-1:0] exResult;
  logic                 exCarry;
  logic                 exOverflow;
  logic                 exZero;
  logic                 exIllegal;

  opDecode opDecode_inst (
    .clk        (clk),
    .rst        (rst),
    .inValid    (inValid),
    .opCode     (opCode),
    .opA        (opA),
    .opB        (opB),
    .decValid   (decValid),
    .decOp      (decOp),
    .decIllegal (decIllegal),
    .decA       (decA),
    .decB       (decB)
  );

  aluExecute aluExecute_inst (
    .decValid   (decValid),
    .decOp      (decOp),
    .decIllegal (decIllegal),
    .decA       (decA),
    .decB       (decB),
    .exValid    (exValid),
    .exResult   (exResult),
    .exCarry    (exCarry),
    .exOverflow (exOverflow),
    .exZero     (exZero),
    .exIllegal  (exIllegal)
  );

  resultStage resultStage_inst (
    .clk        (clk),
    .rst        (rst),
    .exValid    (exValid),
    .exResult   (exResult),
    .exCarry    (exCarry),
    .exOverflow (exOverflow),
    .exZero     (exZero),
    .exIllegal  (exIllegal),
    .outValid   (outValid),
    .result     (result),
    .carry      (carry),
    .overflow   (overflow),
    .zero       (zero),
    .illegalOp  (illegalOp)
  );

endmodule

// File: test/tbClock.sv
`timescale 1ns/1ps

module tbClock (
  output logic clk
);

  localparam time halfPeriod = 50ns;

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

endmodule

// File: test/aluTb.sv
`timescale 1ns/1ps

module aluTb import aluPkg::*; ();

  localparam int randCount = 16;
  localparam int burstCount = 30;
  localparam int totalOps = 6 + 2 * randCount + 3 * randCount + 8 + 4 + burstCount;
  // Reset, idle checks, a drain window per test and the burst gaps.
  localparam int idleCycles = 2 + 4 + 6 * (pipeLatency + 2) + 2 * (burstCount / 5);
  localparam int cycleLimit = totalOps + idleCycles + 20;

  typedef struct packed {
    logic [dataWidth-1:0] res;
    logic                 carry;
    logic                 overflow;
    logic                 zero;
    logic                 illegal;
    int                   issueEdge;
  } expectation;

  logic                 clk;
  logic                 rst;
  logic                 inValid;
  logic [2:0]           opCode;
  logic [dataWidth-1:0] opA;
  logic [dataWidth-1:0] opB;
  logic                 outValid;
  logic [dataWidth-1:0] result;
  logic                 carry;
  logic                 overflow;
  logic                 zero;
  logic                 illegalOp;

  expectation expQ[$];
  expectation front;
  int cycleCount = 0;
  int stimErrors = 0;
  int monitorErrors = 0;
  int opsChecked = 0;
  int testsFailed = 0;
  int testErrorBase = 0;

  tbClock tbClock_inst (.clk(clk));

  aluTop aluTop_inst (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .opCode    (opCode),
    .opA       (opA),
    .opB       (opB),
    .outValid  (outValid),
    .result    (result),
    .carry     (carry),
    .overflow  (overflow),
    .zero      (zero),
    .illegalOp (illegalOp)
  );

  function automatic expectation predict(input logic [2:0] code,
                                         input logic [dataWidth-1:0] a,
                                         input logic [dataWidth-1:0] b);
    expectation e;
    logic [dataWidth:0] wide;
    e = '0;
    wide = '0;
    case (code)
      opAdd: begin
        wide = {1'b0, a} + {1'b0, b};
        e.res = wide[dataWidth-1:0];
        e.carry = wide[dataWidth];
        // Same operand signs but a different sum sign.
        e.overflow = (a[dataWidth-1] == b[dataWidth-1]) &&
                     (wide[dataWidth-1] != a[dataWidth-1]);
      end
      opSub: begin
        wide = {1'b0, a} + {1'b0, ~b} + {{dataWidth{1'b0}}, 1'b1};
        e.res = wide[dataWidth-1:0];
        e.carry = wide[dataWidth];
        e.overflow = (a[dataWidth-1] != b[dataWidth-1]) &&
                     (wide[dataWidth-1] != a[dataWidth-1]);
      end
      opAnd: e.res = a & b;
      opOr: e.res = a | b;
      opXor: e.res = a ^ b;
      opSlt: e.res = {{(dataWidth-1){1'b0}}, $signed(a) < $signed(b)};
      default: e.illegal = 1'b1;
    endcase
    e.zero = !e.illegal && (e.res == '0);
    return e;
  endfunction

  function automatic bit checkValue(input string name, input logic [dataWidth-1:0] expected,
                                    input logic [dataWidth-1:0] actual);
    checkValue = 1'b1;
    assert (actual === expected) else begin
      $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
      checkValue = 1'b0;
    end
  endfunction

  task automatic issueOp(input logic [2:0] code, input logic [dataWidth-1:0] a,
                         input logic [dataWidth-1:0] b);
    expectation e;
    e = predict(code, a, b);
    e.issueEdge = cycleCount;
    expQ.push_back(e);
    inValid = 1'b1;
    opCode = code;
    opA = a;
    opB = b;
    @(posedge clk);
    #1;
    inValid = 1'b0;
  endtask

  task automatic idleCycle();
    inValid = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic finishTest(input string name);
    int errs;
    for (int n = 0; n < pipeLatency + 2 && expQ.size() != 0; n++) begin
      @(posedge clk);
      #1;
    end
    assert (expQ.size() == 0) else begin
      $display("%0d operations of test %s never produced outValid", expQ.size(), name);
      stimErrors++;
      expQ.delete();
    end
    errs = stimErrors + monitorErrors - testErrorBase;
    if (errs != 0) begin
      testsFailed++;
    end
    $display("Test %s: %s with %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
    testErrorBase = stimErrors + monitorErrors;
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  always @(posedge clk) begin
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles with %0d operations pending", cycleCount, expQ.size());
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Outputs are compared mid-cycle, away from the driving edge.
  always @(negedge clk) begin
    if (!rst && outValid) begin
      if (expQ.size() == 0) begin
        $display("outValid pulsed at %0t with no operation pending", $time);
        monitorErrors++;
      end else begin
        front = expQ.pop_front();
        opsChecked++;
        if (!checkValue("result", front.res, result)) monitorErrors++;
        if (!checkValue("carry", dataWidth'(front.carry), dataWidth'(carry))) monitorErrors++;
        if (!checkValue("overflow", dataWidth'(front.overflow), dataWidth'(overflow)))
          monitorErrors++;
        if (!checkValue("zero", dataWidth'(front.zero), dataWidth'(zero))) monitorErrors++;
        if (!checkValue("illegalOp", dataWidth'(front.illegal), dataWidth'(illegalOp)))
          monitorErrors++;
        assert (cycleCount - front.issueEdge == pipeLatency) else begin
          $display("Operation issued after edge %0d reached outValid at edge %0d, not %0d later",
                   front.issueEdge, cycleCount, pipeLatency);
          monitorErrors++;
        end
      end
    end
  end

  initial begin
    void'($urandom(61));
    rst = 1'b1;
    inValid = 1'b0;
    opCode = '0;
    opA = '0;
    opB = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    repeat (4) begin
      if (!checkValue("outValid", '0, dataWidth'(outValid))) stimErrors++;
      if (!checkValue("result", '0, result)) stimErrors++;
      idleCycle();
    end
    finishTest("idle after reset");

    issueOp(opAdd, 32'hFFFF_FFFF, 32'h1);
    issueOp(opSub, 32'h0, 32'h1);
    issueOp(opAdd, 32'h7FFF_FFFF, 32'h1);
    issueOp(opSub, 32'h8000_0000, 32'h1);
    issueOp(opAdd, 32'h0, 32'h0);
    issueOp(opSub, 32'h1234_5678, 32'h1234_5678);
    for (int i = 0; i < randCount; i++) begin
      issueOp(opAdd, $urandom(), $urandom());
      issueOp(opSub, $urandom(), $urandom());
    end
    finishTest("add and subtract");

    for (int i = 0; i < randCount; i++) begin
      issueOp(opAnd, $urandom(), $urandom());
      issueOp(opOr, $urandom(), $urandom());
      issueOp(opXor, $urandom(), $urandom());
    end
    finishTest("bitwise logic");

    // Pairs straddling the sign boundary, plus equal operands.
    issueOp(opSlt, 32'hFFFF_FFFF, 32'h0);
    issueOp(opSlt, 32'h0, 32'hFFFF_FFFF);
    issueOp(opSlt, 32'h7FFF_FFFF, 32'h8000_0000);
    issueOp(opSlt, 32'h8000_0000, 32'h7FFF_FFFF);
    issueOp(opSlt, 32'h5, 32'h5);
    issueOp(opSlt, 32'h8000_0000, 32'h8000_0000);
    issueOp(opSlt, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
    issueOp(opSlt, 32'hFFFF_FFFE, 32'hFFFF_FFFF);
    finishTest("signed set-less-than");

    issueOp(3'd6, $urandom(), $urandom());
    issueOp(3'd7, $urandom(), $urandom());
    issueOp(3'd6, 32'h0, 32'h0);
    issueOp(3'd7, 32'hFFFF_FFFF, 32'h1);
    finishTest("illegal opcodes");

    for (int i = 0; i < burstCount; i++) begin
      issueOp(3'(i % 8), $urandom(), $urandom());
      if (i % 5 == 4) begin
        idleCycle();
        idleCycle();
      end
    end
    finishTest("back-to-back with gaps");

    $display("Summary: 6 tests, %0d failed, %0d operations checked, %0d errors",
             testsFailed, opsChecked, stimErrors + monitorErrors);
    if (testsFailed == 0 && stimErrors + monitorErrors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
hdl/aluPkg.sv
hdl/claBlock4.sv
hdl/claAdder32.sv
hdl/opDecode.sv
hdl/aluExecute.sv
hdl/resultStage.sv
hdl/aluTop.sv
test/tbClock.sv
test/aluTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps --top-module aluTb -f files.f

output=$(./obj_dir/ValuTb)
echo "$output"

if grep -q "ALL TESTS PASSED" <<< "$output"; then
  exit 0
fi
exit 1
